//--- build.f
logic/fu_pkg.sv
logic/fu_alu.sv
logic/fu_br.sv
logic/fu_mult.sv
logic/fu_cmpl_buf.sv
logic/fu_main.sv
test/fu_sva.sv
test/fu_tb.sv

//--- logic/fu_alu.sv
`timescale 1ns/10ps

module fu_alu (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             start_i,
	input  fu_pkg::fu_iss_t  issue_i,
	output fu_pkg::fu_cmpl_t cmpl_o,
	output logic             done_o
);

	import fu_pkg::*;

	logic [XLEN-1:0] opb;
	logic [XLEN-1:0] result;
	fu_cmpl_t        cmpl_nxt;

	// literal form replaces rb with a zero-extended 8-bit constant
	always_comb begin
		if (issue_i.inst.opr.is_literal) begin
			opb = {{(XLEN-8){1'b0}}, issue_i.inst.opr.literal};
		end else begin
			opb = issue_i.opb;
		end
	end

	always_comb begin
		case (issue_i.inst.opr.func)
			ALU_ADDQ:  result = issue_i.opa + opb;
			ALU_SUBQ:  result = issue_i.opa - opb;
			ALU_AND:   result = issue_i.opa & opb;
			ALU_BIS:   result = issue_i.opa | opb;
			ALU_XOR:   result = issue_i.opa ^ opb;
			// shift amount is the low six bits only
			ALU_SLL:   result = issue_i.opa << opb[5:0];
			ALU_SRL:   result = issue_i.opa >> opb[5:0];
			ALU_CMPEQ: result = {{(XLEN-1){1'b0}}, issue_i.opa == opb};
			ALU_CMPLT: result = {{(XLEN-1){1'b0}}, $signed(issue_i.opa) < $signed(opb)};
			default:   result = '0;
		endcase
	end

	always_comb begin
		cmpl_nxt.rob_idx  = issue_i.rob_idx;
		cmpl_nxt.dest_tag = issue_i.dest_tag;
		cmpl_nxt.wr_en    = issue_i.dest_tag != ZERO_REG;
		cmpl_nxt.is_br    = 1'b0;
		cmpl_nxt.taken    = 1'b0;
		cmpl_nxt.value    = result;
		cmpl_nxt.target   = '0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			done_o <= 1'b0;
		end else begin
			done_o <= start_i;
		end
	end

	// record holds until the next start
	always_ff @(posedge clk) begin
		if (start_i) begin
			cmpl_o <= cmpl_nxt;
		end
	end

endmodule

//--- logic/fu_br.sv
`timescale 1ns/10ps

module fu_br (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             start_i,
	input  fu_pkg::fu_iss_t  issue_i,
	output fu_pkg::fu_cmpl_t cmpl_o,
	output logic             done_o
);

	import fu_pkg::*;

	logic [XLEN-1:0] disp_ext;
	logic            taken;
	fu_cmpl_t        cmpl_nxt;

	always_comb begin
		// word displacement, sign extended and scaled by 4
		disp_ext = {{(XLEN-23){issue_i.inst.br.disp[20]}}, issue_i.inst.br.disp, 2'b00};
		case (issue_i.inst.br.opcode)
			BR_BR:   taken = 1'b1;
			BR_BEQ:  taken = issue_i.opa == '0;
			BR_BNE:  taken = issue_i.opa != '0;
			BR_BLT:  taken = issue_i.opa[XLEN-1];
			BR_BGE:  taken = !issue_i.opa[XLEN-1];
			default: taken = 1'b0;
		endcase
		cmpl_nxt.rob_idx  = issue_i.rob_idx;
		cmpl_nxt.dest_tag = issue_i.dest_tag;
		// only the unconditional form writes a link register
		cmpl_nxt.wr_en    = (issue_i.inst.br.opcode == BR_BR) && (issue_i.dest_tag != ZERO_REG);
		cmpl_nxt.is_br    = 1'b1;
		cmpl_nxt.taken    = taken;
		cmpl_nxt.value    = issue_i.npc;
		cmpl_nxt.target   = issue_i.npc + disp_ext;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			done_o <= 1'b0;
		end else begin
			done_o <= start_i;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			cmpl_o <= cmpl_nxt;
		end
	end

endmodule

//--- logic/fu_cmpl_buf.sv
`timescale 1ns/10ps

module fu_cmpl_buf (
	input  logic             clk,
	input  logic             rst_n_i,
	input  fu_pkg::fu_cmpl_t wr_a_i,
	input  logic             wr_a_vld_i,
	input  fu_pkg::fu_cmpl_t wr_b_i,
	input  logic             wr_b_vld_i,
	output fu_pkg::fu_cmpl_t head_o,
	output logic             head_vld_o,
	input  logic             pop_i,
	output logic             credit_ret_o
);

	import fu_pkg::*;

	fu_cmpl_t            mem [CMPL_DEPTH];
	// one extra wrap bit tells full from empty
	logic [CMPL_PTR_W:0] wr_ptr;
	logic [CMPL_PTR_W:0] rd_ptr;
	logic [CMPL_PTR_W:0] b_ptr;
	logic                pop;

	assign head_vld_o   = wr_ptr != rd_ptr;
	assign head_o       = mem[rd_ptr[CMPL_PTR_W-1:0]];
	assign pop          = pop_i && head_vld_o;
	assign credit_ret_o = pop;

	// port b lands behind port a when both fire
	assign b_ptr = wr_ptr + (CMPL_PTR_W+1)'(wr_a_vld_i);

	always_ff @(posedge clk) begin
		if (wr_a_vld_i) begin
			mem[wr_ptr[CMPL_PTR_W-1:0]] <= wr_a_i;
		end
		if (wr_b_vld_i) begin
			mem[b_ptr[CMPL_PTR_W-1:0]] <= wr_b_i;
		end
	end

	// no overflow check, issue credits bound the occupancy
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
		end else begin
			wr_ptr <= wr_ptr + (CMPL_PTR_W+1)'(wr_a_vld_i) + (CMPL_PTR_W+1)'(wr_b_vld_i);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

//--- logic/fu_main.sv
`timescale 1ns/10ps

module fu_main (
	input  logic             clk,
	input  logic             rst_n_i,
	input  fu_pkg::fu_iss_t  issue_i,
	input  logic             iss_vld_i,
	output logic             iss_rdy_o,
	output fu_pkg::fu_cmpl_t cdb_o,
	output logic             cdb_vld_o,
	output logic             preg_wr_en_o,
	input  logic             cdb_rdy_i
);

	import fu_pkg::*;

	logic              alu_start;
	logic              br_start;
	logic              mult_start;
	logic              spend;
	logic [CRED_W-1:0] credits;
	logic              credit_ret;

	fu_cmpl_t          alu_cmpl;
	fu_cmpl_t          br_cmpl;
	fu_cmpl_t          mult_cmpl;
	fu_cmpl_t          port_b;
	logic              alu_done;
	logic              br_done;
	logic              mult_done;
	logic              port_b_vld;

	// steer an accepted issue to one unit
	always_comb begin
		alu_start  = 1'b0;
		br_start   = 1'b0;
		mult_start = 1'b0;
		if (iss_vld_i && iss_rdy_o) begin
			case (issue_i.sel)
				FU_SEL_NONE:  ;
				FU_SEL_ALU:   alu_start = 1'b1;
				FU_SEL_UNCOND_BRANCH, FU_SEL_COND_BRANCH:
				              br_start = 1'b1;
				FU_SEL_MULT:  mult_start = 1'b1;
				default:      ;
			endcase
		end
	end

	// a nop or bad select takes no credit
	assign spend = alu_start || br_start || mult_start;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			credits <= CRED_W'(CMPL_DEPTH);
		end else if (spend && !credit_ret) begin
			credits <= credits - 1'b1;
		end else if (!spend && credit_ret) begin
			credits <= credits + 1'b1;
		end
	end

	assign iss_rdy_o = credits != '0;

	// alu and branch unit never finish together
	assign port_b     = br_done ? br_cmpl : alu_cmpl;
	assign port_b_vld = alu_done || br_done;

	assign preg_wr_en_o = cdb_vld_o && cdb_o.wr_en;

	fu_alu u_alu (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.start_i (alu_start),
		.issue_i (issue_i),
		.cmpl_o  (alu_cmpl),
		.done_o  (alu_done)
	);

	fu_br u_br (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.start_i (br_start),
		.issue_i (issue_i),
		.cmpl_o  (br_cmpl),
		.done_o  (br_done)
	);

	fu_mult u_mult (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.start_i (mult_start),
		.issue_i (issue_i),
		.cmpl_o  (mult_cmpl),
		.done_o  (mult_done)
	);

	// multiply is the older op on a collision, so it takes port a
	fu_cmpl_buf u_cmpl_buf (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.wr_a_i       (mult_cmpl),
		.wr_a_vld_i   (mult_done),
		.wr_b_i       (port_b),
		.wr_b_vld_i   (port_b_vld),
		.head_o       (cdb_o),
		.head_vld_o   (cdb_vld_o),
		.pop_i        (cdb_rdy_i),
		.credit_ret_o (credit_ret)
	);

endmodule

//--- logic/fu_mult.sv
`timescale 1ns/10ps

module fu_mult (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             start_i,
	input  fu_pkg::fu_iss_t  issue_i,
	output fu_pkg::fu_cmpl_t cmpl_o,
	output logic             done_o
);

	import fu_pkg::*;

	logic [MULT_STAGES-1:0] vld_q;
	logic [XLEN-1:0]        pp_q [4];
	logic [XLEN-1:0]        sum_q [2];
	// tags for stages one and two, stage three lives in cmpl_o
	logic [ROB_IDX_W-1:0]   rob_q [MULT_STAGES-1];
	logic [PRF_IDX_W-1:0]   tag_q [MULT_STAGES-1];
	logic                   wr_q [MULT_STAGES-1];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[MULT_STAGES-2:0], start_i};
		end
	end

	assign done_o = vld_q[MULT_STAGES-1];

	// stage 1, opa against each 16-bit slice of opb, kept to 64 bits
	always_ff @(posedge clk) begin
		for (int k = 0; k < 4; k++) begin
			pp_q[k] <= issue_i.opa * (XLEN'(issue_i.opb[k*16 +: 16]) << (k*16));
		end
		rob_q[0] <= issue_i.rob_idx;
		tag_q[0] <= issue_i.dest_tag;
		wr_q[0]  <= issue_i.dest_tag != ZERO_REG;
	end

	// stage 2, pairwise sums
	always_ff @(posedge clk) begin
		sum_q[0] <= pp_q[0] + pp_q[1];
		sum_q[1] <= pp_q[2] + pp_q[3];
		rob_q[1] <= rob_q[0];
		tag_q[1] <= tag_q[0];
		wr_q[1]  <= wr_q[0];
	end

	// stage 3, final add into the record
	always_ff @(posedge clk) begin
		cmpl_o.rob_idx  <= rob_q[1];
		cmpl_o.dest_tag <= tag_q[1];
		cmpl_o.wr_en    <= wr_q[1];
		cmpl_o.is_br    <= 1'b0;
		cmpl_o.taken    <= 1'b0;
		cmpl_o.value    <= sum_q[0] + sum_q[1];
		cmpl_o.target   <= '0;
	end

endmodule

//--- logic/fu_pkg.sv
package fu_pkg;

	// datapath and tag widths
	localparam int XLEN      = 64;
	localparam int ROB_IDX_W = 5;
	localparam int PRF_IDX_W = 6;

	// physical tag that never takes a write
	localparam logic [PRF_IDX_W-1:0] ZERO_REG = 6'd31;

	// unit select codes from the reservation station
	localparam int FU_SEL_W = 3;
	localparam logic [FU_SEL_W-1:0] FU_SEL_NONE          = 3'd0;
	localparam logic [FU_SEL_W-1:0] FU_SEL_ALU           = 3'd1;
	localparam logic [FU_SEL_W-1:0] FU_SEL_UNCOND_BRANCH = 3'd2;
	localparam logic [FU_SEL_W-1:0] FU_SEL_COND_BRANCH   = 3'd3;
	localparam logic [FU_SEL_W-1:0] FU_SEL_MULT          = 3'd4;

	// operate format function field
	// bis sits at 0x28 so that it does not alias addq
	localparam logic [6:0] ALU_ADDQ  = 7'h20;
	localparam logic [6:0] ALU_SUBQ  = 7'h29;
	localparam logic [6:0] ALU_AND   = 7'h00;
	localparam logic [6:0] ALU_BIS   = 7'h28;
	localparam logic [6:0] ALU_XOR   = 7'h40;
	localparam logic [6:0] ALU_SLL   = 7'h39;
	localparam logic [6:0] ALU_SRL   = 7'h34;
	localparam logic [6:0] ALU_CMPEQ = 7'h2d;
	localparam logic [6:0] ALU_CMPLT = 7'h4d;

	// branch format opcodes
	localparam logic [5:0] BR_BR  = 6'h30;
	localparam logic [5:0] BR_BEQ = 6'h39;
	localparam logic [5:0] BR_BNE = 6'h3d;
	localparam logic [5:0] BR_BLT = 6'h3a;
	localparam logic [5:0] BR_BGE = 6'h3e;

	// completion buffer and credits
	localparam int CMPL_DEPTH = 8;
	localparam int CMPL_PTR_W = $clog2(CMPL_DEPTH);
	localparam int CRED_W     = 4;

	// multiplier latency in register stages
	localparam int MULT_STAGES = 3;

	// bits 20:13, rb in the register form, an 8-bit literal otherwise
	typedef struct packed {
		logic [4:0] rb;
		logic [2:0] sbz;
	} fu_lit_t;

	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] ra;
			fu_lit_t    literal;
			logic       is_literal;
			logic [6:0] func;
			logic [4:0] rc;
		} opr;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  ra;
			logic [20:0] disp;
		} br;
	} fu_inst_u;

	typedef struct packed {
		logic [XLEN-1:0]      npc;
		logic [XLEN-1:0]      opa;
		logic [XLEN-1:0]      opb;
		fu_inst_u             inst;
		logic [PRF_IDX_W-1:0] dest_tag;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [FU_SEL_W-1:0]  sel;
	} fu_iss_t;

	typedef struct packed {
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [PRF_IDX_W-1:0] dest_tag;
		logic                 wr_en;
		logic                 is_br;
		logic                 taken;
		logic [XLEN-1:0]      value;
		logic [XLEN-1:0]      target;
	} fu_cmpl_t;

endpackage

//--- test/fu_sva.sv
`timescale 1ns/10ps

module fu_sva (
	input logic             clk,
	input logic             rst_n_i,
	input fu_pkg::fu_iss_t  issue_i,
	input logic             iss_vld_i,
	input logic             iss_rdy_i,
	input fu_pkg::fu_cmpl_t cdb_i,
	input logic             cdb_vld_i,
	input logic             preg_wr_en_i,
	input logic             cdb_rdy_i
);

	import fu_pkg::*;

	int sva_errors = 0;

	// a real op may only be presented while a credit is left
	issue_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
		iss_vld_i && issue_i.sel != FU_SEL_NONE |-> iss_rdy_i)
	else begin
		$error("issue presented with no credit left");
		sva_errors++;
	end

	// stalled head record holds still until the pop
	cdb_holds_when_stalled: assert property (@(posedge clk) disable iff (!rst_n_i)
		cdb_vld_i && !cdb_rdy_i |=> cdb_vld_i && $stable(cdb_i))
	else begin
		$error("bus record changed while stalled");
		sva_errors++;
	end

	reset_values: assert property (@(posedge clk)
		!rst_n_i |=> !cdb_vld_i && !preg_wr_en_i && iss_rdy_i)
	else begin
		$error("outputs not at their reset values");
		sva_errors++;
	end

endmodule

//--- test/fu_tb.sv
`timescale 1ns/10ps

module fu_tb;

	import fu_pkg::*;

	// roughly 300 ops, each stretched up to 8x by back-pressure, plus margin
	localparam int MAX_CYCLES = 20000;

	localparam logic [6:0] ALU_FUNCS [9] = '{ALU_ADDQ, ALU_SUBQ, ALU_AND, ALU_BIS, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_CMPEQ, ALU_CMPLT};
	localparam logic [5:0] BR_OPS [5] = '{BR_BR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE};

	logic       clk;
	logic       rst_n_i;
	fu_iss_t    issue_i;
	logic       iss_vld_i;
	logic       iss_rdy_o;
	fu_cmpl_t   cdb_o;
	logic       cdb_vld_o;
	logic       preg_wr_en_o;
	logic       cdb_rdy_i;

	integer     seed = 30324;
	int         errors = 0;
	int         tests_failed = 0;
	int         test_no = 0;
	int         err_mark = 0;
	int         cycles = 0;
	int         collisions = 0;
	int         tb_cred;
	logic [4:0] rob_ctr = '0;
	logic       rand_rdy = 1'b0;
	fu_cmpl_t   exp_rec [int];
	int         order_q [$];
	// rob indices on their way to the buffer, -1 for an empty slot
	int         mult_pipe [3] = '{-1, -1, -1};
	int         single_slot = -1;

	fu_main dut (.*);

	bind fu_main fu_sva u_sva (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.issue_i      (issue_i),
		.iss_vld_i    (iss_vld_i),
		.iss_rdy_i    (iss_rdy_o),
		.cdb_i        (cdb_o),
		.cdb_vld_i    (cdb_vld_o),
		.preg_wr_en_i (preg_wr_en_o),
		.cdb_rdy_i    (cdb_rdy_i)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped by timeout after %0d cycles", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// credit count after this edge, from the values seen at the edge
	function automatic int next_credits();
		int n;
		n = tb_cred;
		if (cdb_vld_o && cdb_rdy_i) begin
			n++;
		end
		if (iss_vld_i && iss_rdy_o && issue_i.sel != FU_SEL_NONE) begin
			n--;
		end
		return n;
	endfunction

	function automatic fu_cmpl_t model(input fu_iss_t op);
		fu_cmpl_t           r;
		logic [31:0]        w;
		logic [XLEN-1:0]    b;
		logic signed [63:0] a;
		w          = op.inst;
		a          = op.opa;
		r          = '0;
		r.rob_idx  = op.rob_idx;
		r.dest_tag = op.dest_tag;
		r.wr_en    = op.dest_tag != ZERO_REG;
		if (op.sel == FU_SEL_ALU) begin
			// literal in bits 20:13, literal flag in bit 12, function in 11:5
			b = w[12] ? {56'd0, w[20:13]} : op.opb;
			case (w[11:5])
				ALU_ADDQ:  r.value = op.opa + b;
				ALU_SUBQ:  r.value = op.opa - b;
				ALU_AND:   r.value = op.opa & b;
				ALU_BIS:   r.value = op.opa | b;
				ALU_XOR:   r.value = op.opa ^ b;
				ALU_SLL:   r.value = op.opa << b[5:0];
				ALU_SRL:   r.value = op.opa >> b[5:0];
				ALU_CMPEQ: r.value = 64'(op.opa == b);
				ALU_CMPLT: r.value = 64'(a < $signed(b));
				default:   r.value = '0;
			endcase
		end else if (op.sel == FU_SEL_MULT) begin
			r.value = op.opa * op.opb;
		end else begin
			r.is_br  = 1'b1;
			r.value  = op.npc;
			r.target = op.npc + 64'($signed(w[20:0])) * 64'd4;
			r.wr_en  = (w[31:26] == BR_BR) && (op.dest_tag != ZERO_REG);
			case (w[31:26])
				BR_BR:   r.taken = 1'b1;
				BR_BEQ:  r.taken = a == 0;
				BR_BNE:  r.taken = a != 0;
				BR_BLT:  r.taken = a < 0;
				default: r.taken = a >= 0;
			endcase
		end
		return r;
	endfunction

	function automatic fu_iss_t make_op(input logic [FU_SEL_W-1:0] sel, input int sub);
		fu_iss_t op;
		op.npc      = {$random(seed), $random(seed)};
		op.opa      = {$random(seed), $random(seed)};
		op.opb      = {$random(seed), $random(seed)};
		op.inst     = $random(seed);
		op.dest_tag = PRF_IDX_W'($random(seed));
		op.rob_idx  = '0;
		op.sel      = sel;
		if (sub % 7 == 3) begin
			op.dest_tag = ZERO_REG;
		end
		if (sel == FU_SEL_ALU) begin
			op.inst.opr.func = ALU_FUNCS[sub % 9];
			// equal operands so cmpeq also sees a match
			if (sub % 5 == 1) begin
				op.opb = op.opa;
			end
		end else if (sel == FU_SEL_COND_BRANCH || sel == FU_SEL_UNCOND_BRANCH) begin
			op.inst.br.opcode = BR_OPS[sub % 5];
			op.sel = (op.inst.br.opcode == BR_BR) ? FU_SEL_UNCOND_BRANCH : FU_SEL_COND_BRANCH;
			case ((sub / 5) % 3)
				0:       op.opa = '0;
				1:       op.opa[XLEN-1] = 1'b0;
				default: op.opa[XLEN-1] = 1'b1;
			endcase
			if (sub % 2 == 1) begin
				op.inst.br.disp[20] = 1'b1;
			end
		end
		return op;
	endfunction

	task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_pop();
		fu_cmpl_t e;
		int       want;
		want = -1;
		if (order_q.size() != 0) begin
			want = order_q.pop_front();
		end
		check_field("cdb_o.rob_idx", cdb_o.rob_idx, want);
		assert (exp_rec.exists(cdb_o.rob_idx)) else begin
			$display("record with unknown rob_idx %0d reached the bus", cdb_o.rob_idx);
			errors++;
		end
		if (exp_rec.exists(cdb_o.rob_idx)) begin
			e = exp_rec[cdb_o.rob_idx];
			exp_rec.delete(cdb_o.rob_idx);
			check_field("cdb_o.dest_tag", cdb_o.dest_tag, e.dest_tag);
			check_field("cdb_o.wr_en", cdb_o.wr_en, e.wr_en);
			check_field("cdb_o.is_br", cdb_o.is_br, e.is_br);
			check_field("cdb_o.taken", cdb_o.taken, e.taken);
			check_field("cdb_o.value", cdb_o.value, e.value);
			check_field("cdb_o.target", cdb_o.target, e.target);
			check_field("preg_wr_en_o", preg_wr_en_o, e.wr_en);
		end
	endtask

	task automatic accept_op();
		assert (!exp_rec.exists(issue_i.rob_idx)) else begin
			$display("rob_idx %0d issued again before its record popped", issue_i.rob_idx);
			errors++;
		end
		exp_rec[issue_i.rob_idx] = model(issue_i);
		if (issue_i.sel == FU_SEL_MULT) begin
			mult_pipe[0] = issue_i.rob_idx;
		end else begin
			single_slot = issue_i.rob_idx;
		end
	endtask

	// samples at the edge, so it sees the values the DUT acts on
	always @(posedge clk) begin
		if (!rst_n_i) begin
			tb_cred <= CMPL_DEPTH;
		end else begin
			tb_cred <= next_credits();
			assert (iss_rdy_o == (tb_cred != 0)) else begin
				$display("[FAIL] iss_rdy_o got %h exp %h", iss_rdy_o, tb_cred != 0);
				errors++;
			end
			if (cdb_vld_o && cdb_rdy_i) begin
				check_pop();
			end
			// buffer writes at this edge, multiplier port first
			if (mult_pipe[2] >= 0 && single_slot >= 0) begin
				collisions++;
			end
			if (mult_pipe[2] >= 0) begin
				order_q.push_back(mult_pipe[2]);
			end
			if (single_slot >= 0) begin
				order_q.push_back(single_slot);
			end
			mult_pipe[2] = mult_pipe[1];
			mult_pipe[1] = mult_pipe[0];
			mult_pipe[0] = -1;
			single_slot  = -1;
			if (iss_vld_i && iss_rdy_o && issue_i.sel != FU_SEL_NONE) begin
				accept_op();
			end
		end
	end

	task automatic drive_op(input fu_iss_t op);
		op.rob_idx = rob_ctr;
		rob_ctr    = rob_ctr + 1'b1;
		issue_i   <= op;
		iss_vld_i <= 1'b1;
	endtask

	task automatic send_op(input fu_iss_t op);
		do begin
			@(posedge clk);
			iss_vld_i <= 1'b0;
			if (rand_rdy) begin
				cdb_rdy_i <= ($random(seed) % 2) != 0;
			end
		end while (next_credits() == 0);
		drive_op(op);
	endtask

	task automatic drain();
		int n;
		n = 0;
		@(posedge clk);
		iss_vld_i <= 1'b0;
		cdb_rdy_i <= 1'b1;
		rand_rdy = 1'b0;
		@(negedge clk);
		while (exp_rec.num() != 0 && n < 200) begin
			@(negedge clk);
			n++;
		end
		assert (exp_rec.num() == 0) else begin
			$display("%0d issued records never reached the bus", exp_rec.num());
			errors++;
		end
	endtask

	task automatic measure_latency(input fu_iss_t op, input int want);
		int lat;
		send_op(op);
		lat = 0;
		@(posedge clk);
		iss_vld_i <= 1'b0;
		while (!cdb_vld_o && lat < 20) begin
			lat++;
			@(posedge clk);
		end
		assert (lat == want) else begin
			$display("cdb_vld_o rose %0d cycles after issue, expected %0d", lat, want);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		test_no++;
		if (errors == err_mark) begin
			$display("test %0d %s: ok", test_no, name);
		end else begin
			$display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
			tests_failed++;
		end
		err_mark = errors;
	endtask

	initial begin
		int                  n_acc;
		int                  k;
		logic [FU_SEL_W-1:0] sel;
		rst_n_i   = 1'b0;
		iss_vld_i = 1'b0;
		issue_i   = '0;
		cdb_rdy_i = 1'b1;
		repeat (4) @(posedge clk);
		rst_n_i <= 1'b1;
		@(negedge clk);

		assert (!cdb_vld_o && iss_rdy_o) else begin
			$display("outputs not at their reset values after reset");
			errors++;
		end
		measure_latency(make_op(FU_SEL_ALU, 0), 2);
		drain();
		measure_latency(make_op(FU_SEL_MULT, 0), 4);
		drain();
		finish_test("reset and latency");

		for (int i = 0; i < 100; i++) begin
			send_op(make_op(FU_SEL_ALU, i));
		end
		drain();
		finish_test("alu functions");

		for (int i = 0; i < 40; i++) begin
			send_op(make_op(FU_SEL_COND_BRANCH, i));
		end
		drain();
		finish_test("branches");

		// mult, mult, alu, alu lines each alu up with an older multiply
		collisions = 0;
		for (int i = 0; i < 24; i++) begin
			send_op(make_op((i % 4 < 2) ? FU_SEL_MULT : FU_SEL_ALU, i));
		end
		drain();
		assert (collisions > 0) else begin
			$display("no cycle wrote both buffer ports");
			errors++;
		end
		finish_test("multiplier and collisions");

		@(posedge clk);
		cdb_rdy_i <= 1'b0;
		n_acc = 0;
		for (int i = 0; i < 12; i++) begin
			@(posedge clk);
			// issues the DUT took at this edge
			if (iss_vld_i && iss_rdy_o) begin
				n_acc++;
			end
			if (next_credits() != 0) begin
				drive_op(make_op((i % 3 == 0) ? FU_SEL_MULT : FU_SEL_ALU, i));
			end else begin
				iss_vld_i <= 1'b0;
			end
		end
		@(negedge clk);
		assert (!iss_rdy_o && n_acc == 8) else begin
			$display("%0d ops accepted under back-pressure, expected 8", n_acc);
			errors++;
		end
		drain();
		assert (iss_rdy_o) else begin
			$display("iss_rdy_o still low after the buffer drained");
			errors++;
		end
		finish_test("credit back-pressure");

		rand_rdy = 1'b1;
		for (int i = 0; i < 150; i++) begin
			k   = $unsigned($random(seed)) % 8;
			sel = (k < 3) ? FU_SEL_ALU : (k < 5) ? FU_SEL_COND_BRANCH :
				(k < 7) ? FU_SEL_MULT : FU_SEL_NONE;
			send_op(make_op(sel, i));
		end
		drain();
		finish_test("mixed traffic");

		$display("tests %0d, failed %0d, check errors %0d, assertion errors %0d",
			test_no, tests_failed, errors, dut.u_sva.sva_errors);
		if (errors == 0 && dut.u_sva.sva_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
